// File: logic/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W = 32;
    localparam int OFFSET_W = 5;
    localparam int LINE_WORDS = 8;
    localparam int NUM_WAYS = 2;
    localparam int STRB_W = ADDR_W / 8;
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);
    localparam int BYTE_OFF_W = OFFSET_W - WORD_SEL_W;
    localparam int SET_ADDR_W = ADDR_W - OFFSET_W;  // widest possible index or tag

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FILL
    } miss_state_e;

    typedef logic [LINE_WORDS-1:0][ADDR_W-1:0] cache_line_t;  // word 0 in low bits

    typedef struct packed {
        cache_op_e op;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } cache_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;  // line aligned
        cache_line_t line;
    } mem_req_t;

    typedef struct packed {
        logic [NUM_WAYS-1:0][LINE_WORDS-1:0] word_en;
        logic [NUM_WAYS-1:0] tag_we;
        logic [SET_ADDR_W-1:0] index;
        logic [SET_ADDR_W-1:0] tag;
        cache_line_t line;
    } array_wr_t;

endpackage

// File: logic/dcache_arrays.sv
`timescale 1ns/1ps

module dcache_arrays #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_W = $clog2(NUM_SETS),
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W
) (
    input  logic clk,
    input  logic reset,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  dcache_pkg::array_wr_t wr_i,
    output logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0] tag_o,
    output logic [dcache_pkg::NUM_WAYS-1:0] valid_o,
    output dcache_pkg::cache_line_t [dcache_pkg::NUM_WAYS-1:0] line_o
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0] wr_tag;
    logic same_index;

    assign wr_index = wr_i.index[INDEX_W-1:0];
    assign wr_tag = wr_i.tag[TAG_W-1:0];
    assign same_index = wr_index == rd_index_i;  // write-first bypass

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [TAG_W-1:0] tag_mem [NUM_SETS];
        logic [TAG_W-1:0] tag_q;
        logic [NUM_SETS-1:0] valid_q;
        logic valid_rd_q;

        always_ff @(posedge clk) begin
            if (wr_i.tag_we[w]) begin
                tag_mem[wr_index] <= wr_tag;
            end
            if (wr_i.tag_we[w] && same_index) begin
                tag_q <= wr_tag;
            end else begin
                tag_q <= tag_mem[rd_index_i];
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= '0;
                valid_rd_q <= 1'b0;
            end else begin
                if (wr_i.tag_we[w]) begin
                    valid_q[wr_index] <= 1'b1;  // fills only, never cleared
                end
                valid_rd_q <= (wr_i.tag_we[w] && same_index) || valid_q[rd_index_i];
            end
        end

        assign tag_o[w] = tag_q;
        assign valid_o[w] = valid_rd_q;

        // one bank per word so a store touches a single word
        for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
            logic [ADDR_W-1:0] bank_mem [NUM_SETS];
            logic [ADDR_W-1:0] word_q;

            always_ff @(posedge clk) begin
                if (wr_i.word_en[w][b]) begin
                    bank_mem[wr_index] <= wr_i.line[b];
                end
                if (wr_i.word_en[w][b] && same_index) begin
                    word_q <= wr_i.line[b];
                end else begin
                    word_q <= bank_mem[rd_index_i];
                end
            end

            assign line_o[w][b] = word_q;
        end
    end

endmodule

// File: logic/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_W = $clog2(NUM_SETS),
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W
) (
    input  logic clk,
    input  logic reset,
    input  logic req_valid_i,
    input  dcache_pkg::cache_req_t req_i,
    output logic req_ready_o,
    input  logic busy_i,
    input  logic victim_way_i,
    input  logic fill_valid_i,
    input  dcache_pkg::cache_line_t fill_line_i,
    output logic [INDEX_W-1:0] rd_index_o,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0] tag_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] valid_i,
    input  dcache_pkg::cache_line_t [dcache_pkg::NUM_WAYS-1:0] line_i,
    output dcache_pkg::array_wr_t wr_o,
    output logic stage_valid_o,
    output dcache_pkg::cache_req_t stage_req_o,
    output logic hit_o,
    output logic hit_way_o,
    output logic resp_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] resp_rdata_o
);
    import dcache_pkg::*;

    logic stage_valid_q;
    cache_req_t stage_q;
    logic accept;
    logic [NUM_WAYS-1:0] way_hit;
    logic hit;
    logic hit_way;
    logic miss;
    logic hold;
    logic store_hit;
    logic [INDEX_W-1:0] stage_index;
    logic [TAG_W-1:0] stage_tag;
    logic [WORD_SEL_W-1:0] word_sel;
    cache_line_t base_line;
    cache_line_t merged_line;

    function automatic logic [ADDR_W-1:0] merge_word(input logic [ADDR_W-1:0] old_word,
                                                     input logic [ADDR_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
        logic [ADDR_W-1:0] result;
        result = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign stage_index = stage_q.addr[OFFSET_W +: INDEX_W];
    assign stage_tag = stage_q.addr[ADDR_W-1 -: TAG_W];
    assign word_sel = stage_q.addr[BYTE_OFF_W +: WORD_SEL_W];

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_cmp
        assign way_hit[w] = valid_i[w] && (tag_i[w] == stage_tag);
    end

    assign hit = stage_valid_q && |way_hit;
    assign hit_way = way_hit[1];
    assign miss = stage_valid_q && !hit && !busy_i;
    assign hold = busy_i || miss;  // stall from the miss cycle on
    assign req_ready_o = !hold;
    assign accept = req_valid_i && req_ready_o;
    assign rd_index_o = hold ? stage_index : req_i.addr[OFFSET_W +: INDEX_W];
    assign store_hit = hit && !busy_i && (stage_q.op == OP_WRITE);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid_q <= 1'b0;
        end else if (accept) begin
            stage_valid_q <= 1'b1;
        end else if (fill_valid_i || !hold) begin
            stage_valid_q <= 1'b0;  // retired by hit or fill
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q <= req_i;
        end
    end

    assign base_line = fill_valid_i ? fill_line_i : line_i[hit_way];

    always_comb begin
        merged_line = base_line;
        if (stage_q.op == OP_WRITE) begin
            merged_line[word_sel] = merge_word(base_line[word_sel], stage_q.wdata, stage_q.strb);
        end
    end

    always_comb begin
        wr_o = '0;
        wr_o.index = SET_ADDR_W'(stage_index);
        wr_o.tag = SET_ADDR_W'(stage_tag);
        wr_o.line = merged_line;
        if (fill_valid_i) begin
            wr_o.word_en[victim_way_i] = '1;
            wr_o.tag_we[victim_way_i] = 1'b1;
        end else if (store_hit) begin
            wr_o.word_en[hit_way][word_sel] = 1'b1;
        end
    end

    assign resp_valid_o = fill_valid_i || (hit && !busy_i);
    assign resp_rdata_o = base_line[word_sel];

    assign stage_valid_o = stage_valid_q;
    assign stage_req_o = stage_q;
    assign hit_o = hit;
    assign hit_way_o = hit_way;

endmodule

// File: logic/dcache_miss_ctrl.sv
`timescale 1ns/1ps

module dcache_miss_ctrl #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_W = $clog2(NUM_SETS),
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W
) (
    input  logic clk,
    input  logic reset,
    input  logic stage_valid_i,
    input  dcache_pkg::cache_req_t stage_req_i,
    input  logic hit_i,
    input  logic hit_way_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0] tag_i,
    input  dcache_pkg::cache_line_t [dcache_pkg::NUM_WAYS-1:0] line_i,
    output logic busy_o,
    output logic victim_way_o,
    output logic fill_valid_o,
    output dcache_pkg::cache_line_t fill_line_o,
    output logic rd_req_o,
    output dcache_pkg::mem_req_t rd_o,
    input  logic mem_ret_valid_i,
    input  dcache_pkg::cache_line_t mem_ret_line_i,
    output logic wr_req_o,
    output dcache_pkg::mem_req_t wr_o,
    input  logic mem_wr_done_i
);
    import dcache_pkg::*;

    miss_state_e state_q;
    miss_state_e state_d;
    logic [NUM_SETS-1:0] lru_q;  // way to evict next
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
    logic [INDEX_W-1:0] index;
    logic is_write;
    logic miss;
    logic victim_dirty;
    cache_line_t fill_q;
    mem_req_t wb_q;

    assign index = stage_req_i.addr[OFFSET_W +: INDEX_W];
    assign is_write = stage_req_i.op == OP_WRITE;
    assign victim_way_o = lru_q[index];
    assign victim_dirty = dirty_q[index][victim_way_o];
    assign miss = (state_q == ST_IDLE) && stage_valid_i && !hit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = victim_dirty ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_wr_done_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_ret_valid_i) begin
                    state_d = ST_FILL;
                end
            end
            default: state_d = ST_IDLE;  // fill lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
            dirty_q <= '0;
        end else if ((state_q == ST_IDLE) && stage_valid_i && hit_i) begin
            lru_q[index] <= !hit_way_i;
            if (is_write) begin
                dirty_q[index][hit_way_i] <= 1'b1;
            end
        end else if (state_q == ST_FILL) begin
            lru_q[index] <= !victim_way_o;
            dirty_q[index][victim_way_o] <= is_write;  // clean after a read refill
        end
    end

    // victim snapshot, taken while the arrays still show it
    always_ff @(posedge clk) begin
        if (miss) begin
            wb_q.addr <= {tag_i[victim_way_o], index, {OFFSET_W{1'b0}}};
            wb_q.line <= line_i[victim_way_o];
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_REFILL) && mem_ret_valid_i) begin
            fill_q <= mem_ret_line_i;
        end
    end

    assign busy_o = state_q != ST_IDLE;
    assign fill_valid_o = state_q == ST_FILL;
    assign fill_line_o = fill_q;

    assign rd_req_o = state_q == ST_REFILL;
    assign rd_o.addr = {stage_req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign rd_o.line = '0;  // address only

    assign wr_req_o = state_q == ST_WRITEBACK;
    assign wr_o = wb_q;

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_W = $clog2(NUM_SETS),
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W
) (
    input  logic clk,
    input  logic reset,
    input  logic req_valid_i,
    input  dcache_pkg::cache_req_t req_i,
    output logic req_ready_o,
    output logic resp_valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] resp_rdata_o,
    output logic rd_req_o,
    output dcache_pkg::mem_req_t rd_o,
    input  logic mem_ret_valid_i,
    input  dcache_pkg::cache_line_t mem_ret_line_i,
    output logic wr_req_o,
    output dcache_pkg::mem_req_t wr_o,
    input  logic mem_wr_done_i
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0] rd_index;
    array_wr_t arr_wr;
    logic [NUM_WAYS-1:0][TAG_W-1:0] way_tag;
    logic [NUM_WAYS-1:0] way_valid;
    cache_line_t [NUM_WAYS-1:0] way_line;
    logic busy;
    logic victim_way;
    logic fill_valid;
    cache_line_t fill_line;
    logic stage_valid;
    cache_req_t stage_req;
    logic hit;
    logic hit_way;

    dcache_arrays #(
        .NUM_SETS(NUM_SETS)
    ) u_arrays (
        .clk(clk),
        .reset(reset),
        .rd_index_i(rd_index),
        .wr_i(arr_wr),
        .tag_o(way_tag),
        .valid_o(way_valid),
        .line_o(way_line)
    );

    dcache_lookup #(
        .NUM_SETS(NUM_SETS)
    ) u_lookup (
        .clk(clk),
        .reset(reset),
        .req_valid_i(req_valid_i),
        .req_i(req_i),
        .req_ready_o(req_ready_o),
        .busy_i(busy),
        .victim_way_i(victim_way),
        .fill_valid_i(fill_valid),
        .fill_line_i(fill_line),
        .rd_index_o(rd_index),
        .tag_i(way_tag),
        .valid_i(way_valid),
        .line_i(way_line),
        .wr_o(arr_wr),
        .stage_valid_o(stage_valid),
        .stage_req_o(stage_req),
        .hit_o(hit),
        .hit_way_o(hit_way),
        .resp_valid_o(resp_valid_o),
        .resp_rdata_o(resp_rdata_o)
    );

    dcache_miss_ctrl #(
        .NUM_SETS(NUM_SETS)
    ) u_miss_ctrl (
        .clk(clk),
        .reset(reset),
        .stage_valid_i(stage_valid),
        .stage_req_i(stage_req),
        .hit_i(hit),
        .hit_way_i(hit_way),
        .tag_i(way_tag),
        .line_i(way_line),
        .busy_o(busy),
        .victim_way_o(victim_way),
        .fill_valid_o(fill_valid),
        .fill_line_o(fill_line),
        .rd_req_o(rd_req_o),
        .rd_o(rd_o),
        .mem_ret_valid_i(mem_ret_valid_i),
        .mem_ret_line_i(mem_ret_line_i),
        .wr_req_o(wr_req_o),
        .wr_o(wr_o),
        .mem_wr_done_i(mem_wr_done_i)
    );

endmodule

// File: verification/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic clk,
    input logic reset,
    input logic busy_i,
    input logic req_ready_i,
    input logic rd_req_i,
    input dcache_pkg::mem_req_t rd_i,
    input logic mem_ret_valid_i,
    input logic wr_req_i,
    input dcache_pkg::mem_req_t wr_i,
    input logic mem_wr_done_i
);
    int fail_count = 0;

    a_one_req: assert property (@(posedge clk) disable iff (reset) !(rd_req_i && wr_req_i))
        else begin
            fail_count++;
            $error("read and write requests to memory are high together");
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (reset)
        rd_req_i && !mem_ret_valid_i |=> rd_req_i && $stable(rd_i))
        else begin
            fail_count++;
            $error("read request dropped or changed before the memory returned the line");
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (reset)
        wr_req_i && !mem_wr_done_i |=> wr_req_i && $stable(wr_i))
        else begin
            fail_count++;
            $error("writeback request dropped or changed before the memory acknowledged it");
        end

    a_busy_stall: assert property (@(posedge clk) disable iff (reset) busy_i |-> !req_ready_i)
        else begin
            fail_count++;
            $error("cache accepts requests while the miss controller is busy");
        end

endmodule

// miss controller signals as seen at the top level
bind dcache_top dcache_checker u_checker (
    .clk(clk),
    .reset(reset),
    .busy_i(busy),
    .req_ready_i(req_ready_o),
    .rd_req_i(rd_req_o),
    .rd_i(rd_o),
    .mem_ret_valid_i(mem_ret_valid_i),
    .wr_req_i(wr_req_o),
    .wr_i(wr_o),
    .mem_wr_done_i(mem_wr_done_i)
);

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_SETS = 128;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 21;
    localparam int MISS_CYCLES = 20;  // writeback plus refill at the longest delay
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * MISS_CYCLES;

    typedef struct packed {
        cache_op_e op;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic hit;
        logic wb;
        logic [ADDR_W-1:0] wb_addr;  // victim line when wb is set
    } test_entry_t;

    logic clk;
    logic reset;
    logic req_valid;
    cache_req_t req;
    logic req_ready;
    logic resp_valid;
    logic [ADDR_W-1:0] resp_rdata;
    logic rd_req;
    mem_req_t rd_cmd;
    logic mem_ret_valid;
    cache_line_t mem_ret_line;
    logic wr_req;
    mem_req_t wr_cmd;
    logic mem_wr_done;

    integer seed = 32'h712b09ea;
    int err_count = 0;
    int check_total = 0;
    int wb_count = 0;
    int rd_count = 0;
    int cycle_count;
    int mem_wait;
    logic mem_pending = 1'b0;
    mem_req_t wb_seen;
    mem_req_t rd_seen;
    cache_line_t shadow_mem [logic [ADDR_W-1:0]];
    logic [7:0] ref_mem [logic [ADDR_W-1:0]];

    // index 2 is addr 0x.040, index 5 is addr 0x.0a0
    test_entry_t tests [NUM_TESTS] = '{
        '{OP_READ,  32'h0000_1040, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_1044, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, 32'h0000_1048, 32'haabb_ccdd, 4'b0101, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_1048, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, 32'h0000_2050, 32'h1234_5678, 4'b1111, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_2044, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_205c, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_2050, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_3040, 32'h0000_0000, 4'b0000, 1'b0, 1'b1, 32'h0000_1040},
        '{OP_READ,  32'h0000_2040, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_1048, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_1040, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, 32'h0000_00a4, 32'h00c0_ffee, 4'b0011, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_00a4, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_WRITE, 32'h0000_00a4, 32'h9900_0000, 4'b1000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_00a4, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_10a0, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_20a0, 32'h0000_0000, 4'b0000, 1'b0, 1'b1, 32'h0000_00a0},
        '{OP_READ,  32'h0000_00a4, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0},
        '{OP_READ,  32'h0000_4050, 32'h0000_0000, 4'b0000, 1'b0, 1'b1, 32'h0000_2040},
        '{OP_READ,  32'h0000_2050, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0}
    };

    dcache_top #(
        .NUM_SETS(NUM_SETS)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .req_valid_i(req_valid),
        .req_i(req),
        .req_ready_o(req_ready),
        .resp_valid_o(resp_valid),
        .resp_rdata_o(resp_rdata),
        .rd_req_o(rd_req),
        .rd_o(rd_cmd),
        .mem_ret_valid_i(mem_ret_valid),
        .mem_ret_line_i(mem_ret_line),
        .wr_req_o(wr_req),
        .wr_o(wr_cmd),
        .mem_wr_done_i(mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory content before any writeback, hashed from the word address
    function automatic logic [ADDR_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] w;
        w = {addr[ADDR_W-1:2], 2'b00};
        return (w * 32'h9e37_79b1) ^ (w >> 13) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic cache_line_t mem_line(input logic [ADDR_W-1:0] line_addr);
        cache_line_t line;
        if (shadow_mem.exists(line_addr)) begin
            return shadow_mem[line_addr];
        end
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k] = init_word(line_addr + 4 * k);
        end
        return line;
    endfunction

    function automatic logic [ADDR_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] w;
        base = {addr[ADDR_W-1:2], 2'b00};
        w = init_word(base);
        for (int b = 0; b < STRB_W; b++) begin
            if (ref_mem.exists(base + b)) begin
                w[8*b +: 8] = ref_mem[base + b];
            end
        end
        return w;
    endfunction

    function automatic cache_line_t ref_line(input logic [ADDR_W-1:0] line_addr);
        cache_line_t line;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k] = ref_word(line_addr + 4 * k);
        end
        return line;
    endfunction

    function automatic void ref_write(input logic [ADDR_W-1:0] addr,
                                      input logic [ADDR_W-1:0] data,
                                      input logic [STRB_W-1:0] strb);
        logic [ADDR_W-1:0] base;
        base = {addr[ADDR_W-1:2], 2'b00};
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
    endfunction

    task automatic check_word(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        check_total++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
        check_total++;
        if (got.addr !== exp.addr) begin
            err_count++;
            $display("Mismatch %s.addr: got %h, expected %h", name, got.addr, exp.addr);
        end
        if (got.line !== exp.line) begin
            err_count++;
            $display("Mismatch %s.line: got %h, expected %h", name, got.line, exp.line);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_total++;
        if (got != exp) begin
            err_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // answers one request at a time after a random delay
    always @(posedge clk) begin
        mem_ret_valid <= 1'b0;
        mem_wr_done <= 1'b0;
        if (reset) begin
            mem_pending <= 1'b0;
        end else if ((rd_req || wr_req) && !mem_ret_valid && !mem_wr_done) begin
            if (!mem_pending) begin
                mem_pending <= 1'b1;
                mem_wait <= $random(seed) & 3;
            end else if (mem_wait > 0) begin
                mem_wait <= mem_wait - 1;
            end else begin
                mem_pending <= 1'b0;
                if (wr_req) begin
                    shadow_mem[wr_cmd.addr] = wr_cmd.line;
                    wb_seen = wr_cmd;
                    wb_count++;
                    mem_wr_done <= 1'b1;
                end else begin
                    mem_ret_line <= mem_line(rd_cmd.addr);
                    rd_seen = rd_cmd;
                    rd_count++;
                    mem_ret_valid <= 1'b1;
                end
            end
        end
    end

    task automatic send_request(input test_entry_t t, output int latency,
                                output logic [ADDR_W-1:0] rdata);
        cache_req_t r;
        r.op = t.op;
        r.addr = t.addr;
        r.wdata = t.wdata;
        r.strb = t.strb;
        @(posedge clk);
        req_valid <= 1'b1;
        req <= r;
        do begin
            @(posedge clk);
        end while (!req_ready);
        req_valid <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!resp_valid);
        rdata = resp_rdata;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        int latency;
        int wb_before;
        int rd_before;
        int err_before;
        int total_errors;
        logic [ADDR_W-1:0] rdata;
        mem_req_t exp_wb;
        mem_req_t exp_rd;

        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        mem_ret_valid = 1'b0;
        mem_ret_line = '0;
        mem_wr_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            wb_before = wb_count;
            rd_before = rd_count;
            err_before = err_count;
            send_request(tests[i], latency, rdata);
            check_count("refills", rd_count - rd_before, tests[i].hit ? 0 : 1);
            check_count("writebacks", wb_count - wb_before, tests[i].wb ? 1 : 0);
            if (tests[i].hit) begin
                check_count("hit latency", latency, 1);
            end else begin
                exp_rd.addr = tests[i].addr & ~ADDR_W'(LINE_WORDS * STRB_W - 1);
                exp_rd.line = '0;  // address only
                check_mem_req("rd_o", rd_seen, exp_rd);
            end
            if (tests[i].wb) begin
                exp_wb.addr = tests[i].wb_addr;
                exp_wb.line = ref_line(tests[i].wb_addr);
                check_mem_req("wr_o", wb_seen, exp_wb);
            end
            if (tests[i].op == OP_READ) begin
                check_word("resp_rdata_o", rdata, ref_word(tests[i].addr));
            end else begin
                ref_write(tests[i].addr, tests[i].wdata, tests[i].strb);  // store now visible
            end
            $display("test %0d %s addr %h latency %0d: %s", i,
                     tests[i].op == OP_WRITE ? "write" : "read", tests[i].addr, latency,
                     err_count == err_before ? "ok" : "error");
        end

        total_errors = err_count + DUT.u_checker.fail_count;
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_total, total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/dcache_pkg.sv
logic/dcache_arrays.sv
logic/dcache_lookup.sv
logic/dcache_miss_ctrl.sv
logic/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/dcache_arrays.sv
  - logic/dcache_lookup.sv
  - logic/dcache_miss_ctrl.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - verification/dcache_checker.sv
      - verification/dcache_tb.sv
